// ==== Bender.yml ====
package:
  name: mem_access

sources:
  - hdl/mem_pkg.sv
  - hdl/pipe_reg.sv
  - hdl/data_ram.sv
  - hdl/mem_stage.sv
  - hdl/mem_access_top.sv
  - target: test
    files:
      - testbench/mem_access_chk.sv
      - testbench/mem_access_tb.sv

// ==== files.f ====
hdl/mem_pkg.sv
hdl/pipe_reg.sv
hdl/data_ram.sv
hdl/mem_stage.sv
hdl/mem_access_top.sv
testbench/mem_access_chk.sv
testbench/mem_access_tb.sv

// ==== hdl/data_ram.sv ====
`timescale 1ns/1ns

module data_ram #(
    parameter int WORDS   = mem_pkg::RAM_WORDS,
    parameter int LATENCY = mem_pkg::RAM_LATENCY
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  mem_pkg::dcache_req_t  req_i,
    output mem_pkg::dcache_resp_t resp_o
);
    import mem_pkg::*;

    localparam int AW = $clog2(WORDS);

    bus32_t ram_q [WORDS] = '{default: '0};

    logic [AW-1:0] index;

    // response delay line
    logic [LATENCY-1:0] ok_q;
    logic [LATENCY-1:0] we_q;
    bus32_t             data_q [LATENCY];

    // word address, byte offset dropped
    assign index = req_i.addr[AW+1:2];

    always_ff @(posedge clk) begin
        if (req_i.valid && req_i.we) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.wstrb[b]) begin
                    ram_q[index][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // strobe and write flag
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ok_q <= '0;
            we_q <= '0;
        end else begin
            ok_q[0] <= req_i.valid;
            we_q[0] <= req_i.valid && req_i.we;
            for (int s = 1; s < LATENCY; s++) begin
                ok_q[s] <= ok_q[s-1];
                we_q[s] <= we_q[s-1];
            end
        end
    end

    // read word sampled at the request edge
    always_ff @(posedge clk) begin
        data_q[0] <= ram_q[index];
        for (int s = 1; s < LATENCY; s++) begin
            data_q[s] <= data_q[s-1];
        end
    end

    assign resp_o.data_ok = ok_q[LATENCY-1];

    // stores answer with a zero word
    assign resp_o.rdata = we_q[LATENCY-1] ? '0 : data_q[LATENCY-1];

endmodule

// ==== hdl/mem_access_top.sv ====
`timescale 1ns/1ns

module mem_access_top #(
    parameter int ISSUE_WIDTH = mem_pkg::ISSUE_WIDTH,
    parameter int RAM_WORDS   = mem_pkg::RAM_WORDS,
    parameter int RAM_LATENCY = mem_pkg::RAM_LATENCY
) (
    input  logic                   clk,
    input  logic                   reset_i,
    input  mem_pkg::ex_mem_t       ex_i [ISSUE_WIDTH],
    output mem_pkg::mem_wb_t       wb_o [ISSUE_WIDTH],
    output mem_pkg::push_forward_t fwd_o [ISSUE_WIDTH],
    output mem_pkg::mem_ctrl_t     ctrl_o [ISSUE_WIDTH],
    output logic                   pause_o
);
    import mem_pkg::*;

    ex_mem_t      ex_mem_q [ISSUE_WIDTH];
    mem_wb_t      stage_wb [ISSUE_WIDTH];
    dcache_req_t  dcache_req;
    dcache_resp_t dcache_resp;

    // held while the memory stage waits
    pipe_reg #(
        .payload_t(ex_mem_t),
        .N        (ISSUE_WIDTH)
    ) ex_mem_reg (
        .clk     (clk),
        .reset_i (reset_i),
        .stall_i (pause_o),
        .bubble_i(1'b0),
        .d_i     (ex_i),
        .q_o     (ex_mem_q)
    );

    mem_stage #(
        .ISSUE_WIDTH(ISSUE_WIDTH)
    ) mem_stage_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .mem_i        (ex_mem_q),
        .dcache_req_o (dcache_req),
        .dcache_resp_i(dcache_resp),
        .wb_o         (stage_wb),
        .fwd_o        (fwd_o),
        .ctrl_o       (ctrl_o),
        .pause_o      (pause_o)
    );

    // stands in for the dcache
    data_ram #(
        .WORDS  (RAM_WORDS),
        .LATENCY(RAM_LATENCY)
    ) data_ram_i (
        .clk    (clk),
        .reset_i(reset_i),
        .req_i  (dcache_req),
        .resp_o (dcache_resp)
    );

    // bubbles go to writeback during a pause
    pipe_reg #(
        .payload_t(mem_wb_t),
        .N        (ISSUE_WIDTH)
    ) mem_wb_reg (
        .clk     (clk),
        .reset_i (reset_i),
        .stall_i (1'b0),
        .bubble_i(pause_o),
        .d_i     (stage_wb),
        .q_o     (wb_o)
    );

endmodule

// ==== hdl/mem_pkg.sv ====
package mem_pkg;

    // default sizes, overridden from the top level
    parameter int ISSUE_WIDTH = 2;
    parameter int RAM_WORDS   = 256;
    parameter int RAM_LATENCY = 2;

    typedef logic [31:0] bus32_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [13:0] csr_addr_t;

    typedef enum logic [7:0] {
        ALU_NOP  = 8'h00,
        ALU_LDB  = 8'h01,
        ALU_LDBU = 8'h02,
        ALU_LDH  = 8'h03,
        ALU_LDHU = 8'h04,
        ALU_LDW  = 8'h05,
        ALU_LLW  = 8'h06,
        ALU_STB  = 8'h07,
        ALU_STH  = 8'h08,
        ALU_STW  = 8'h09,
        ALU_ERTN = 8'h0a,
        ALU_IDLE = 8'h0b
    } aluop_t;

    // exception codes, ALE follows the LoongArch ecode
    typedef logic [5:0] exc_cause_t;

    localparam exc_cause_t EXC_NONE = 6'h00;
    localparam exc_cause_t EXC_ALE  = 6'h09;

    // execute to memory
    typedef struct packed {
        logic       valid;
        bus32_t     pc;
        aluop_t     aluop;
        bus32_t     mem_addr;
        bus32_t     store_data;
        logic       reg_write_en;
        reg_addr_t  reg_write_addr;
        bus32_t     reg_write_data;
        logic       is_llw_scw;
        logic       csr_write_en;
        csr_addr_t  csr_addr;
        bus32_t     csr_write_data;
        logic       is_privilege;
        exc_cause_t exception_cause;
    } ex_mem_t;

    // memory to writeback
    typedef struct packed {
        logic      valid;
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
        bus32_t    reg_write_data;
        logic      is_llw_scw;
        logic      csr_write_en;
        csr_addr_t csr_write_addr;
        bus32_t    csr_write_data;
    } mem_wb_t;

    // bypass to dispatch
    typedef struct packed {
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
        bus32_t    reg_write_data;
    } push_forward_t;

    // status towards the control unit
    typedef struct packed {
        logic       is_exception;
        exc_cause_t exception_cause;
        bus32_t     pc;
        bus32_t     exception_addr;
        logic       is_privilege;
        logic       is_ertn;
        logic       is_idle;
    } mem_ctrl_t;

    typedef struct packed {
        logic       valid;
        logic       we;
        bus32_t     addr;
        logic [3:0] wstrb;
        bus32_t     wdata;
    } dcache_req_t;

    typedef struct packed {
        logic   data_ok;
        bus32_t rdata;
    } dcache_resp_t;

endpackage

// ==== hdl/mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage #(
    parameter int ISSUE_WIDTH = mem_pkg::ISSUE_WIDTH
) (
    input  logic                   clk,
    input  logic                   reset_i,
    input  mem_pkg::ex_mem_t       mem_i [ISSUE_WIDTH],
    output mem_pkg::dcache_req_t   dcache_req_o,
    input  mem_pkg::dcache_resp_t  dcache_resp_i,
    output mem_pkg::mem_wb_t       wb_o [ISSUE_WIDTH],
    output mem_pkg::push_forward_t fwd_o [ISSUE_WIDTH],
    output mem_pkg::mem_ctrl_t     ctrl_o [ISSUE_WIDTH],
    output logic                   pause_o
);
    import mem_pkg::*;

    logic [1:0] offset;
    logic       is_load;
    logic       is_store;
    logic       is_half;
    logic       is_word;
    logic       mem_op;
    logic       misaligned;
    logic       ale;
    logic       access;
    logic       req_sent_q;
    bus32_t     cache_data;
    bus32_t     shifted;
    bus32_t     load_data;

    assign offset = mem_i[0].mem_addr[1:0];

    // lane 0 opcode decode
    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        is_half  = 1'b0;
        is_word  = 1'b0;
        case (mem_i[0].aluop)
            ALU_LDB, ALU_LDBU: begin
                is_load = 1'b1;
            end
            ALU_LDH, ALU_LDHU: begin
                is_load = 1'b1;
                is_half = 1'b1;
            end
            ALU_LDW, ALU_LLW: begin
                is_load = 1'b1;
                is_word = 1'b1;
            end
            ALU_STB: begin
                is_store = 1'b1;
            end
            ALU_STH: begin
                is_store = 1'b1;
                is_half  = 1'b1;
            end
            ALU_STW: begin
                is_store = 1'b1;
                is_word  = 1'b1;
            end
            default: begin
                is_load = 1'b0;
            end
        endcase
    end

    // an entry that already carries an exception skips memory
    assign mem_op = mem_i[0].valid && (is_load || is_store)
                    && mem_i[0].exception_cause == EXC_NONE;
    assign misaligned = (is_half && offset[0]) || (is_word && offset != 2'b00);
    assign ale        = mem_op && misaligned;
    assign access     = mem_op && !misaligned;

    // held until data_ok
    assign pause_o = access && !dcache_resp_i.data_ok;

    // one request per access
    always_ff @(posedge clk) begin
        if (reset_i) begin
            req_sent_q <= 1'b0;
        end else if (dcache_resp_i.data_ok) begin
            req_sent_q <= 1'b0;
        end else if (dcache_req_o.valid) begin
            req_sent_q <= 1'b1;
        end
    end

    always_comb begin
        dcache_req_o       = '0;
        dcache_req_o.valid = access && !req_sent_q;
        dcache_req_o.we    = is_store;
        dcache_req_o.addr  = mem_i[0].mem_addr;
        case (mem_i[0].aluop)
            ALU_STB: begin
                dcache_req_o.wstrb = 4'b0001 << offset;
                dcache_req_o.wdata = {24'b0, mem_i[0].store_data[7:0]} << {offset, 3'b000};
            end
            ALU_STH: begin
                dcache_req_o.wstrb = offset[1] ? 4'b1100 : 4'b0011;
                dcache_req_o.wdata = {16'b0, mem_i[0].store_data[15:0]} << {offset, 3'b000};
            end
            ALU_STW: begin
                dcache_req_o.wstrb = 4'b1111;
                dcache_req_o.wdata = mem_i[0].store_data;
            end
            default: begin
                dcache_req_o.wstrb = 4'b0000;
            end
        endcase
    end

    // load extraction
    assign cache_data = dcache_resp_i.data_ok ? dcache_resp_i.rdata : '0;
    assign shifted    = cache_data >> {offset, 3'b000};

    always_comb begin
        case (mem_i[0].aluop)
            ALU_LDB:          load_data = {{24{shifted[7]}}, shifted[7:0]};
            ALU_LDBU:         load_data = {24'b0, shifted[7:0]};
            ALU_LDH:          load_data = {{16{shifted[15]}}, shifted[15:0]};
            ALU_LDHU:         load_data = {16'b0, shifted[15:0]};
            ALU_LDW, ALU_LLW: load_data = cache_data;
            default:          load_data = mem_i[0].reg_write_data;
        endcase
    end

    // writeback, forward and ctrl per lane
    always_comb begin
        exc_cause_t cause;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            cause = (i == 0 && ale) ? EXC_ALE : mem_i[i].exception_cause;

            wb_o[i].valid          = mem_i[i].valid;
            wb_o[i].reg_write_en   = mem_i[i].reg_write_en && cause == EXC_NONE;
            wb_o[i].reg_write_addr = mem_i[i].reg_write_addr;
            wb_o[i].reg_write_data = (i == 0) ? load_data : mem_i[i].reg_write_data;
            wb_o[i].is_llw_scw     = mem_i[i].is_llw_scw;
            wb_o[i].csr_write_en   = mem_i[i].csr_write_en;
            wb_o[i].csr_write_addr = mem_i[i].csr_addr;
            wb_o[i].csr_write_data = mem_i[i].csr_write_data;

            fwd_o[i].reg_write_en   = wb_o[i].valid && wb_o[i].reg_write_en;
            fwd_o[i].reg_write_addr = wb_o[i].reg_write_addr;
            fwd_o[i].reg_write_data = wb_o[i].reg_write_data;

            ctrl_o[i].is_exception    = mem_i[i].valid && cause != EXC_NONE;
            ctrl_o[i].exception_cause = cause;
            ctrl_o[i].pc              = mem_i[i].pc;
            ctrl_o[i].exception_addr  = mem_i[i].mem_addr;

            // only lane 0 reports these
            ctrl_o[i].is_privilege = (i == 0) && mem_i[i].valid && mem_i[i].is_privilege;
            ctrl_o[i].is_ertn      = (i == 0) && mem_i[i].valid && cause == EXC_NONE
                                     && mem_i[i].aluop == ALU_ERTN;
            ctrl_o[i].is_idle      = (i == 0) && mem_i[i].valid && mem_i[i].aluop == ALU_IDLE;
        end
    end

endmodule

// ==== hdl/pipe_reg.sv ====
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic,
    parameter int  N         = 1
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     stall_i,
    input  logic     bubble_i,
    input  payload_t d_i [N],
    output payload_t q_o [N]
);

    // a zeroed entry reads as not valid
    always_ff @(posedge clk) begin
        if (reset_i || bubble_i) begin
            for (int i = 0; i < N; i++) begin
                q_o[i] <= '0;
            end
        end else if (!stall_i) begin
            for (int i = 0; i < N; i++) begin
                q_o[i] <= d_i[i];
            end
        end
    end

endmodule

// ==== testbench/mem_access_chk.sv ====
`timescale 1ns/1ns

module mem_access_chk (
    input logic                  clk,
    input logic                  reset_i,
    input mem_pkg::dcache_req_t  req_i,
    input mem_pkg::dcache_resp_t resp_i,
    input logic                  pause_i
);

    logic outstanding_q;

    // tracks the request in flight
    always_ff @(posedge clk) begin
        if (reset_i) begin
            outstanding_q <= 1'b0;
        end else if (resp_i.data_ok) begin
            outstanding_q <= 1'b0;
        end else if (req_i.valid) begin
            outstanding_q <= 1'b1;
        end
    end

    single_request: assert property (@(posedge clk) disable iff (reset_i)
        req_i.valid |-> !outstanding_q)
        else $error("request issued while another one is outstanding");

    ok_after_request: assert property (@(posedge clk) disable iff (reset_i)
        resp_i.data_ok |-> outstanding_q)
        else $error("data_ok without a prior request");

    pause_falls_on_ok: assert property (@(posedge clk) disable iff (reset_i)
        $fell(pause_i) |-> resp_i.data_ok)
        else $error("pause dropped without data_ok");

endmodule

bind mem_stage mem_access_chk chk_i (
    .clk    (clk),
    .reset_i(reset_i),
    .req_i  (dcache_req_o),
    .resp_i (dcache_resp_i),
    .pause_i(pause_o)
);

// ==== testbench/mem_access_tb.sv ====
`timescale 1ns/1ns

module mem_access_tb;
    import mem_pkg::*;

    localparam int MEM_BYTES  = RAM_WORDS * 4;
    localparam int WB_TIMEOUT = 20;

    logic    clk = 1'b0;
    logic    reset_i;
    ex_mem_t ex_i [ISSUE_WIDTH];

    mem_wb_t       wb_o [ISSUE_WIDTH];
    push_forward_t fwd_o [ISSUE_WIDTH];
    mem_ctrl_t     ctrl_o [ISSUE_WIDTH];
    logic          pause_o;

    integer     seed;
    logic [7:0] ref_mem [MEM_BYTES];

    // snapshots taken while an entry waits for writeback
    int            wb_cycles;
    int            pause_count;
    mem_ctrl_t     stage_ctrl [ISSUE_WIDTH];
    push_forward_t last_fwd [ISSUE_WIDTH];

    mem_access_top dut_i (
        .clk    (clk),
        .reset_i(reset_i),
        .ex_i   (ex_i),
        .wb_o   (wb_o),
        .fwd_o  (fwd_o),
        .ctrl_o (ctrl_o),
        .pause_o(pause_o)
    );

    always #50 clk = ~clk;

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic ex_mem_t make_op(input aluop_t op, input bus32_t addr,
                                        input bus32_t data, input reg_addr_t rd);
        ex_mem_t e;
        e                = '0;
        e.valid          = 1'b1;
        e.pc             = 32'h1c00_0000 | addr;
        e.aluop          = op;
        e.mem_addr       = addr;
        e.store_data     = data;
        e.reg_write_en   = !(op inside {ALU_STB, ALU_STH, ALU_STW, ALU_ERTN, ALU_IDLE});
        e.reg_write_addr = rd;
        // alu result for non-memory ops
        e.reg_write_data = data;
        e.is_llw_scw     = (op == ALU_LLW);
        return e;
    endfunction

    // little-endian view of the reference bytes
    function automatic bus32_t ref_load(input aluop_t op, input bus32_t addr);
        logic [7:0] b [4];
        for (int k = 0; k < 4; k++) begin
            b[k] = ref_mem[(addr + k) % MEM_BYTES];
        end
        case (op)
            ALU_LDB:  return {{24{b[0][7]}}, b[0]};
            ALU_LDBU: return {24'b0, b[0]};
            ALU_LDH:  return {{16{b[1][7]}}, b[1], b[0]};
            ALU_LDHU: return {16'b0, b[1], b[0]};
            default:  return {b[3], b[2], b[1], b[0]};
        endcase
    endfunction

    task automatic ref_store(input aluop_t op, input bus32_t addr, input bus32_t data);
        int n;
        n = (op == ALU_STB) ? 1 : (op == ALU_STH) ? 2 : 4;
        for (int k = 0; k < n; k++) begin
            ref_mem[(addr + k) % MEM_BYTES] = data[8*k +: 8];
        end
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (pause_o) begin
            cycles++;
            if (cycles >= WB_TIMEOUT) begin
                $display("timed out waiting for pause_o to drop before a new entry");
                $display("*** FAILED ***");
                $fatal(1, "pause_o stuck high");
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_wb();
        int   cycles;
        logic done;
        cycles      = 0;
        done        = 1'b0;
        pause_count = 0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (cycles == 1) begin
                stage_ctrl[0] = ctrl_o[0];
                stage_ctrl[1] = ctrl_o[1];
            end
            if (pause_o) begin
                pause_count++;
            end
            if (wb_o[0].valid) begin
                done = 1'b1;
            end else if (cycles >= WB_TIMEOUT) begin
                $display("timed out waiting for a valid writeback on lane 0");
                $display("*** FAILED ***");
                $fatal(1, "no writeback within %0d cycles", WB_TIMEOUT);
            end else begin
                last_fwd[0] = fwd_o[0];
                last_fwd[1] = fwd_o[1];
            end
        end
        wb_cycles = cycles;
    endtask

    // present one entry pair, then follow it to writeback
    task automatic run_access(input ex_mem_t e0, input ex_mem_t e1,
                              input int exp_cycles, input int exp_pause);
        wait_ready();
        @(posedge clk);
        ex_i[0] <= e0;
        ex_i[1] <= e1;
        @(posedge clk);
        ex_i[0] <= '0;
        ex_i[1] <= '0;
        wait_wb();
        check("writeback latency", exp_cycles, wb_cycles);
        check("pause_o cycles", exp_pause, pause_count);
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            check($sformatf("fwd_o[%0d].reg_write_en", i),
                  wb_o[i].valid && wb_o[i].reg_write_en, last_fwd[i].reg_write_en);
            check($sformatf("fwd_o[%0d].reg_write_addr", i),
                  wb_o[i].reg_write_addr, last_fwd[i].reg_write_addr);
            check($sformatf("fwd_o[%0d].reg_write_data", i),
                  wb_o[i].reg_write_data, last_fwd[i].reg_write_data);
        end
    endtask

    task automatic do_store(input aluop_t op, input bus32_t addr, input bus32_t data);
        ref_store(op, addr, data);
        run_access(make_op(op, addr, data, 5'd0), '0, RAM_LATENCY + 2, RAM_LATENCY);
        check("wb_o[0].reg_write_en", 1'b0, wb_o[0].reg_write_en);
    endtask

    task automatic do_load(input aluop_t op, input bus32_t addr);
        reg_addr_t rd;
        rd    = $random(seed);
        rd[0] = 1'b1;
        run_access(make_op(op, addr, 32'h0, rd), '0, RAM_LATENCY + 2, RAM_LATENCY);
        check("wb_o[0].reg_write_en", 1'b1, wb_o[0].reg_write_en);
        check("wb_o[0].reg_write_addr", rd, wb_o[0].reg_write_addr);
        check("wb_o[0].reg_write_data", ref_load(op, addr), wb_o[0].reg_write_data);
        check("wb_o[0].is_llw_scw", op == ALU_LLW, wb_o[0].is_llw_scw);
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check("pause_o", 1'b0, pause_o);
        check("dcache_req_o.valid", 1'b0, dut_i.mem_stage_i.dcache_req_o.valid);
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            check($sformatf("wb_o[%0d].valid", i), 1'b0, wb_o[i].valid);
            check($sformatf("ctrl_o[%0d].is_exception", i), 1'b0, ctrl_o[i].is_exception);
            check($sformatf("ctrl_o[%0d].is_privilege", i), 1'b0, ctrl_o[i].is_privilege);
            check($sformatf("ctrl_o[%0d].is_ertn", i), 1'b0, ctrl_o[i].is_ertn);
            check($sformatf("ctrl_o[%0d].is_idle", i), 1'b0, ctrl_o[i].is_idle);
        end
    endtask

    task automatic test_word_access();
        bus32_t addr;
        for (int k = 0; k < 4; k++) begin
            addr = $random(seed) & 32'h0000_03fc;
            do_store(ALU_STW, addr, $random(seed));
            do_load((k % 2) ? ALU_LLW : ALU_LDW, addr);
        end
    endtask

    task automatic test_subword_loads();
        bus32_t base;
        base = $random(seed) & 32'h0000_03fc;
        for (int off = 0; off < 4; off++) begin
            do_store(ALU_STB, base + off, $random(seed));
            do_load(ALU_LDB, base + off);
            do_load(ALU_LDBU, base + off);
        end
        for (int off = 0; off < 4; off += 2) begin
            do_store(ALU_STH, base + off, $random(seed));
            do_load(ALU_LDH, base + off);
            do_load(ALU_LDHU, base + off);
            do_load(ALU_LDB, base + off + 1);
            do_load(ALU_LDBU, base + off + 1);
        end
    endtask

    task automatic check_misaligned(input aluop_t op, input bus32_t addr);
        run_access(make_op(op, addr, $random(seed), 5'd7), '0, 2, 0);
        check("ctrl_o[0].is_exception", 1'b1, stage_ctrl[0].is_exception);
        check("ctrl_o[0].exception_cause", EXC_ALE, stage_ctrl[0].exception_cause);
        check("ctrl_o[0].exception_addr", addr, stage_ctrl[0].exception_addr);
        check("ctrl_o[0].pc", 32'h1c00_0000 | addr, stage_ctrl[0].pc);
        check("wb_o[0].reg_write_en", 1'b0, wb_o[0].reg_write_en);
    endtask

    task automatic test_misaligned();
        bus32_t base;
        base = $random(seed) & 32'h0000_03f8;
        do_store(ALU_STW, base, $random(seed));
        check_misaligned(ALU_LDH, base + 1);
        check_misaligned(ALU_LDHU, base + 3);
        check_misaligned(ALU_LDW, base + 2);
        check_misaligned(ALU_STW, base + 2);
        // the dropped store must leave memory as it was
        do_load(ALU_LDW, base);
        do_load(ALU_LDW, base + 4);
    endtask

    task automatic test_lane1_forward();
        bus32_t    addr;
        bus32_t    alu0;
        bus32_t    alu1;
        reg_addr_t rd1;
        ex_mem_t   e0;
        ex_mem_t   e1;
        addr = $random(seed) & 32'h0000_03fc;
        alu0 = $random(seed);
        alu1 = $random(seed);
        rd1  = 5'd19;
        run_access(make_op(ALU_NOP, 32'h0, alu0, 5'd4), make_op(ALU_NOP, 32'h0, alu1, rd1),
                   2, 0);
        check("wb_o[0].reg_write_data", alu0, wb_o[0].reg_write_data);
        check("wb_o[1].reg_write_data", alu1, wb_o[1].reg_write_data);
        alu1              = $random(seed);
        e0                = make_op(ALU_LDW, addr, 32'h0, 5'd5);
        e0.csr_addr       = 14'h0180;
        e0.csr_write_data = $random(seed);
        e1                = make_op(ALU_NOP, 32'h0, alu1, rd1);
        e1.pc             = 32'h1c00_0004;
        e1.csr_write_en   = 1'b1;
        e1.csr_addr       = 14'h0006;
        e1.csr_write_data = $random(seed);
        run_access(e0, e1, RAM_LATENCY + 2, RAM_LATENCY);
        check("wb_o[0].reg_write_data", ref_load(ALU_LDW, addr), wb_o[0].reg_write_data);
        check("wb_o[1].valid", 1'b1, wb_o[1].valid);
        check("wb_o[1].reg_write_en", 1'b1, wb_o[1].reg_write_en);
        check("wb_o[1].reg_write_addr", rd1, wb_o[1].reg_write_addr);
        check("wb_o[1].reg_write_data", alu1, wb_o[1].reg_write_data);
        // csr fields only pass through
        check("wb_o[0].csr_write_en", 1'b0, wb_o[0].csr_write_en);
        check("wb_o[0].csr_write_addr", e0.csr_addr, wb_o[0].csr_write_addr);
        check("wb_o[0].csr_write_data", e0.csr_write_data, wb_o[0].csr_write_data);
        check("wb_o[1].csr_write_en", 1'b1, wb_o[1].csr_write_en);
        check("wb_o[1].csr_write_addr", e1.csr_addr, wb_o[1].csr_write_addr);
        check("wb_o[1].csr_write_data", e1.csr_write_data, wb_o[1].csr_write_data);
        check("ctrl_o[0].pc", 32'h1c00_0000 | addr, stage_ctrl[0].pc);
        check("ctrl_o[1].pc", 32'h1c00_0004, stage_ctrl[1].pc);
        check("ctrl_o[1].is_exception", 1'b0, stage_ctrl[1].is_exception);
    endtask

    task automatic check_flags(input logic priv, input logic ertn, input logic idle);
        check("ctrl_o[0].is_privilege", priv, stage_ctrl[0].is_privilege);
        check("ctrl_o[0].is_ertn", ertn, stage_ctrl[0].is_ertn);
        check("ctrl_o[0].is_idle", idle, stage_ctrl[0].is_idle);
        check("ctrl_o[1].is_privilege", 1'b0, stage_ctrl[1].is_privilege);
        check("ctrl_o[1].is_ertn", 1'b0, stage_ctrl[1].is_ertn);
        check("ctrl_o[1].is_idle", 1'b0, stage_ctrl[1].is_idle);
    endtask

    task automatic test_control_flags();
        ex_mem_t e0;
        ex_mem_t e1;
        e0              = make_op(ALU_ERTN, 32'h0, 32'h0, 5'd0);
        e0.is_privilege = 1'b1;
        e1              = e0;
        run_access(e0, e1, 2, 0);
        check_flags(1'b1, 1'b1, 1'b0);
        e0 = make_op(ALU_IDLE, 32'h0, 32'h0, 5'd0);
        e1 = make_op(ALU_IDLE, 32'h0, 32'h0, 5'd0);
        run_access(e0, e1, 2, 0);
        check_flags(1'b0, 1'b0, 1'b1);
        // ertn that already carries an exception
        e0                 = make_op(ALU_ERTN, 32'h0, 32'h0, 5'd0);
        e0.is_privilege    = 1'b1;
        e0.exception_cause = EXC_ALE;
        run_access(e0, '0, 2, 0);
        check_flags(1'b1, 1'b0, 1'b0);
        check("ctrl_o[0].is_exception", 1'b1, stage_ctrl[0].is_exception);
    endtask

    initial begin
        seed    = 32993;
        reset_i = 1'b1;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            ex_i[i] = '0;
        end
        for (int k = 0; k < MEM_BYTES; k++) begin
            ref_mem[k] = 8'h00;
        end
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;

        test_reset_state();
        test_word_access();
        test_subword_loads();
        test_misaligned();
        test_lane1_forward();
        test_control_flags();

        $display("*** PASSED ***");
        $finish;
    end

endmodule
